//--- source/txdma_pkg.sv
package txdma_pkg;

    // **************************************************
    // Widths
    // **************************************************
    typedef logic [31:0] desc_t;        // Descriptor control word
    typedef logic [31:0] addr_t;        // Byte address
    typedef logic [31:0] data_t;        // Memory word
    typedef logic [7:0]  byte_t;        // Stream byte
    typedef logic [6:0]  bd_index_t;    // Ring position
    typedef logic [15:0] frame_len_t;   // Frame length in bytes
    typedef logic [13:0] word_cnt_t;    // Words per job
    typedef logic [1:0]  last_byte_t;   // Last valid byte lane
    typedef logic [8:0]  tx_status_t;   // MAC status field
    typedef logic [4:0]  fifo_cnt_t;    // Holds 0 to FIFO_DEPTH

    // **************************************************
    // Descriptor layout
    // **************************************************
    localparam int BIT_LEN_H  = 31;     // Length field top
    localparam int BIT_LEN_L  = 16;
    localparam int BIT_READY  = 15;     // Owned by the DMA
    localparam int BIT_IRQ    = 14;     // Interrupt on completion
    localparam int BIT_WRAP   = 13;     // Last entry of the ring
    localparam int BIT_PAD    = 12;
    localparam int BIT_CRC    = 11;
    localparam int BIT_STAT_H = 8;      // Status field top
    localparam int BIT_STAT_L = 0;

    // Underrun, retry limit, late collision, defer, carrier lost
    localparam tx_status_t STAT_ERR_MASK = 9'h10F;

    localparam int FIFO_DEPTH = 16;     // Words
    localparam int FIFO_AW    = 4;

    typedef enum logic [2:0] {
        RING_IDLE,
        RING_BD_READ,                   // Poll current descriptor
        RING_DMA,                       // Buffer fetch running
        RING_STATUS,                    // Wait for MAC status
        RING_BD_WRITE                   // Writeback
    } ring_state_t;

    typedef enum logic {
        SER_IDLE,
        SER_SEND
    } ser_state_t;

endpackage

interface dma_job_if;
    import txdma_pkg::*;

    logic       start;                  // One-cycle request
    addr_t      base;                   // Word-aligned buffer start
    word_cnt_t  words;
    last_byte_t last_byte;
    logic       done;                   // Last word stored

    modport ctrl   (output start, base, words, last_byte, input done);
    modport reader (input start, base, words, last_byte, output done);
endinterface

interface word_if;
    import txdma_pkg::*;

    data_t      data;
    last_byte_t last_byte;
    logic       sof;
    logic       eof;
    logic       valid;
    logic       ready;

    modport source (output data, last_byte, sof, eof, valid, input ready);
    modport sink   (input data, last_byte, sof, eof, valid, output ready);
endinterface

//--- source/bd_ring_ctrl.sv
module bd_ring_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  tx_en,
    input  txdma_pkg::bd_index_t  max_tx_bd,
    input  logic                  bd_wait,
    input  txdma_pkg::desc_t      bd_desc,
    input  txdma_pkg::addr_t      bd_ptr,
    input  txdma_pkg::tx_status_t tx_stat,
    input  logic                  tx_stat_valid,
    output logic                  bd_read,
    output logic                  bd_write,
    output txdma_pkg::bd_index_t  bd_index,
    output txdma_pkg::desc_t      bd_writedata,
    output logic                  tx_stat_ack,
    output logic                  per_packet_pad,
    output logic                  per_packet_crc,
    output logic                  txb_irq,
    output logic                  txe_irq,
    dma_job_if.ctrl               job
);
    import txdma_pkg::*;

    ring_state_t state;
    desc_t       desc;                  // Loaded descriptor
    addr_t       ptr;                   // Loaded buffer pointer
    tx_status_t  stat;                  // Captured MAC status
    frame_len_t  desc_len;
    logic [16:0] len_round;             // Length plus 3, no overflow
    logic        bd_rd_ok;              // Ready descriptor taken
    logic        bd_wr_ok;
    logic        stat_err;

    assign desc_len  = desc[BIT_LEN_H:BIT_LEN_L];
    assign len_round = {1'b0, desc_len} + 17'd3;

    assign bd_read     = (state == RING_BD_READ);
    assign bd_write    = (state == RING_BD_WRITE);
    assign bd_rd_ok    = bd_read & ~bd_wait & bd_desc[BIT_READY];
    assign bd_wr_ok    = bd_write & ~bd_wait;
    assign tx_stat_ack = (state == RING_STATUS) & tx_stat_valid;   // Same-cycle accept
    assign stat_err    = |(stat & STAT_ERR_MASK);

    assign job.base      = {ptr[31:2], 2'b00};       // Low bits ignored
    assign job.words     = len_round[15:2];          // Round up to words
    assign job.last_byte = desc_len[1:0] - 2'd1;     // (len - 1) mod 4

    assign per_packet_pad = desc[BIT_PAD];
    assign per_packet_crc = desc[BIT_CRC];

    always_comb begin
        bd_writedata                        = desc;
        bd_writedata[BIT_READY]             = 1'b0;  // Hand back to software
        bd_writedata[BIT_STAT_H:BIT_STAT_L] = stat;
    end

    // **************************************************
    // Ring FSM
    // **************************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= RING_IDLE;
        end else begin
            unique case (state)
                RING_IDLE: begin
                    if (tx_en) begin
                        state <= RING_BD_READ;
                    end
                end
                RING_BD_READ: begin
                    if (bd_rd_ok) begin
                        state <= RING_DMA;   // Otherwise poll again
                    end
                end
                RING_DMA: begin
                    if (job.done) begin
                        state <= RING_STATUS;
                    end
                end
                RING_STATUS: begin
                    if (tx_stat_valid) begin
                        state <= RING_BD_WRITE;
                    end
                end
                RING_BD_WRITE: begin
                    if (~bd_wait) begin
                        state <= RING_IDLE;
                    end
                end
                default: state <= RING_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bd_index  <= '0;
            job.start <= 1'b0;
            txb_irq   <= 1'b0;
            txe_irq   <= 1'b0;
        end else begin
            job.start <= bd_rd_ok;                   // One cycle after accept
            txb_irq   <= bd_wr_ok & desc[BIT_IRQ] & ~stat_err;
            txe_irq   <= bd_wr_ok & desc[BIT_IRQ] & stat_err;
            if (state == RING_IDLE && !tx_en) begin
                bd_index <= '0;                      // Disabled, restart ring
            end else if (bd_wr_ok) begin
                if (desc[BIT_WRAP] || bd_index == max_tx_bd) begin
                    bd_index <= '0;
                end else begin
                    bd_index <= bd_index + 7'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bd_rd_ok) begin
            desc <= bd_desc;
            ptr  <= bd_ptr;
        end
        if (tx_stat_ack) begin
            stat <= tx_stat;
        end
    end

    // Buffer fetch may only finish while the ring waits for it
    a_done_in_dma: assert property (@(posedge clk) disable iff (reset)
        job.done |-> (state == RING_DMA));

endmodule

//--- source/buffer_reader.sv
module buffer_reader (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 av_waitrequest,
    input  txdma_pkg::data_t     av_readdata,
    input  logic                 av_readdatavalid,
    input  txdma_pkg::fifo_cnt_t free_words,
    output logic                 av_read,
    output txdma_pkg::addr_t     av_address,
    dma_job_if.reader            job,
    word_if.source               wout
);
    import txdma_pkg::*;

    logic       active;                 // Job in progress
    addr_t      addr;                   // Next read address
    word_cnt_t  words;
    word_cnt_t  issued;                 // Reads accepted
    word_cnt_t  returned;               // Words back from memory
    last_byte_t job_last;
    fifo_cnt_t  in_flight;              // Accepted, not yet in FIFO
    logic       credit_ok;
    logic       rd_ok;
    logic       wr_ok;
    logic       ret_last;

    // Room for every outstanding word plus the one being issued
    assign credit_ok = ({1'b0, in_flight} + 6'd1) <= {1'b0, free_words};
    // Free space minus in-flight never shrinks, so the request stays up under wait
    assign av_read    = active & (issued != words) & credit_ok;
    assign av_address = addr;
    assign rd_ok      = av_read & ~av_waitrequest;
    assign wr_ok      = wout.valid & wout.ready;
    assign ret_last   = (returned == words - 14'd1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active     <= 1'b0;
            issued     <= '0;
            returned   <= '0;
            in_flight  <= '0;
            wout.valid <= 1'b0;
            job.done   <= 1'b0;
        end else begin
            wout.valid <= av_readdatavalid;         // Present next cycle
            job.done   <= wr_ok & wout.eof;
            if (job.start) begin
                active   <= 1'b1;
                issued   <= '0;
                returned <= '0;
            end else begin
                if (wr_ok && wout.eof) begin
                    active <= 1'b0;
                end
                if (rd_ok) begin
                    issued <= issued + 14'd1;
                end
                if (av_readdatavalid) begin
                    returned <= returned + 14'd1;
                end
            end
            case ({rd_ok, wr_ok})
                2'b10:   in_flight <= in_flight + 5'd1;
                2'b01:   in_flight <= in_flight - 5'd1;
                default: in_flight <= in_flight;    // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (job.start) begin
            words    <= job.words;
            job_last <= job.last_byte;
            addr     <= job.base;
        end else if (rd_ok) begin
            addr <= addr + 32'd4;
        end
        if (av_readdatavalid) begin
            wout.data      <= av_readdata;
            wout.sof       <= (returned == '0);
            wout.eof       <= ret_last;
            wout.last_byte <= ret_last ? job_last : 2'd3;   // Full word unless last
        end
    end

    a_credit: assert property (@(posedge clk) disable iff (reset)
        in_flight <= fifo_cnt_t'(FIFO_DEPTH));

endmodule

//--- source/word_fifo.sv
module word_fifo (
    input  logic                 clk,
    input  logic                 reset,
    output txdma_pkg::fifo_cnt_t free_words,
    word_if.sink                 win,
    word_if.source               wout
);
    import txdma_pkg::*;

    data_t              data_mem [FIFO_DEPTH];
    logic [3:0]         tag_mem  [FIFO_DEPTH];   // sof, eof, last byte
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    fifo_cnt_t          count;
    logic               push;
    logic               pop;

    assign win.ready  = (count != fifo_cnt_t'(FIFO_DEPTH));
    assign wout.valid = (count != '0);
    assign push       = win.valid & win.ready;
    assign pop        = wout.valid & wout.ready;
    assign free_words = fifo_cnt_t'(FIFO_DEPTH) - count;

    // Show-ahead head entry
    assign wout.data = data_mem[rd_ptr];
    assign {wout.sof, wout.eof, wout.last_byte} = tag_mem[rd_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;            // Wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 5'd1;
                2'b01:   count <= count - 5'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= win.data;
            tag_mem[wr_ptr]  <= {win.sof, win.eof, win.last_byte};
        end
    end

    // Reader credit must keep the FIFO from ever being offered a word when full
    a_no_ovf: assert property (@(posedge clk) disable iff (reset) win.valid |-> win.ready);
    a_no_udf: assert property (@(posedge clk) disable iff (reset) wout.ready |-> wout.valid);

endmodule

//--- source/byte_serializer.sv
module byte_serializer (
    input  logic             clk,
    input  logic             reset,
    input  logic             tx_ack,
    output txdma_pkg::byte_t tx_data,
    output logic             tx_dv,
    output logic             tx_sop,
    output logic             tx_eop,
    word_if.sink             win
);
    import txdma_pkg::*;

    ser_state_t state;
    last_byte_t byte_idx;               // Lane of head word, LSB first
    logic       last_in_word;
    logic       xfer;

    assign tx_dv        = (state == SER_SEND) & win.valid;   // Drops when FIFO runs dry
    assign tx_data      = win.data[{byte_idx, 3'b000} +: 8];
    assign last_in_word = (byte_idx == win.last_byte);
    assign xfer         = tx_dv & tx_ack;
    assign tx_sop       = tx_dv & (byte_idx == 2'd0) & win.sof;
    assign tx_eop       = tx_dv & last_in_word & win.eof;
    assign win.ready    = xfer & last_in_word;               // Pop on last lane

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= SER_IDLE;
            byte_idx <= '0;
        end else begin
            unique case (state)
                SER_IDLE: begin
                    byte_idx <= '0;
                    if (win.valid) begin
                        state <= SER_SEND;
                    end
                end
                SER_SEND: begin
                    if (xfer) begin
                        if (last_in_word) begin
                            byte_idx <= '0;
                            if (win.eof) begin
                                state <= SER_IDLE;   // Frame complete
                            end
                        end else begin
                            byte_idx <= byte_idx + 2'd1;
                        end
                    end
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

    // Stalled byte and its markers hold until taken
    a_hold: assert property (@(posedge clk) disable iff (reset)
        (tx_dv && !tx_ack) |=> (tx_dv && $stable(tx_data) && $stable(tx_sop) && $stable(tx_eop)));

endmodule

//--- source/eth_txdma.sv
module eth_txdma (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  tx_en,
    input  txdma_pkg::bd_index_t  max_tx_bd,
    input  logic                  bd_wait,
    input  txdma_pkg::desc_t      bd_desc,
    input  txdma_pkg::addr_t      bd_ptr,
    input  txdma_pkg::tx_status_t tx_stat,
    input  logic                  tx_stat_valid,
    output logic                  bd_read,
    output logic                  bd_write,
    output txdma_pkg::bd_index_t  bd_index,
    output txdma_pkg::desc_t      bd_writedata,
    output logic                  tx_stat_ack,
    output logic                  per_packet_pad,
    output logic                  per_packet_crc,
    output logic                  txb_irq,
    output logic                  txe_irq,
    input  logic                  av_waitrequest,
    input  txdma_pkg::data_t      av_readdata,
    input  logic                  av_readdatavalid,
    output logic                  av_read,
    output txdma_pkg::addr_t      av_address,
    input  logic                  tx_ack,
    output txdma_pkg::byte_t      tx_data,
    output logic                  tx_dv,
    output logic                  tx_sop,
    output logic                  tx_eop
);
    import txdma_pkg::*;

    fifo_cnt_t free_words;              // FIFO space for read credit

    dma_job_if job ();                  // Ring to reader
    word_if    rd_word ();              // Reader to FIFO
    word_if    fifo_word ();            // FIFO to serializer

    // **************************************************
    // Descriptor side, then data path
    // **************************************************
    bd_ring_ctrl    bd_ring_ctrl_inst    (.*, .job(job));
    buffer_reader   buffer_reader_inst   (.*, .job(job), .wout(rd_word));
    word_fifo       word_fifo_inst       (.*, .win(rd_word), .wout(fifo_word));
    byte_serializer byte_serializer_inst (.*, .win(fifo_word));

endmodule

//--- testbench/tb_eth_txdma.sv
module tb_eth_txdma;
    import txdma_pkg::*;

    localparam int N_FRAMES  = 24;
    localparam int N_SLOTS   = 8;
    localparam int MEM_WORDS = 4096;
    localparam int PERIOD    = 40;
    localparam int MAX_LEN   = 128;     // Bytes, longer than the FIFO holds

    logic       clk;
    logic       reset;
    logic       tx_en;
    bd_index_t  max_tx_bd;
    logic       bd_wait;
    desc_t      bd_desc;
    addr_t      bd_ptr;
    tx_status_t tx_stat;
    logic       tx_stat_valid;
    logic       bd_read;
    logic       bd_write;
    bd_index_t  bd_index;
    desc_t      bd_writedata;
    logic       tx_stat_ack;
    logic       per_packet_pad;
    logic       per_packet_crc;
    logic       txb_irq;
    logic       txe_irq;
    logic       av_waitrequest;
    data_t      av_readdata;
    logic       av_readdatavalid;
    logic       av_read;
    addr_t      av_address;
    logic       tx_ack;
    byte_t      tx_data;
    logic       tx_dv;
    logic       tx_sop;
    logic       tx_eop;

    integer     seed = 32'h19a7_6284;
    data_t      mem [MEM_WORDS];            // Frame buffer memory
    desc_t      desc_ram [N_SLOTS];         // Descriptor control words
    addr_t      ptr_ram [N_SLOTS];          // Buffer pointers
    int         ready_in [N_SLOTS];         // Cycles until software sets ready
    int         due_q [$];                  // Read return cycle, in order
    data_t      rdata_q [$];
    int         last_due;
    int         cyc;
    int         rearm_slot;
    bd_index_t  exp_idx;                    // Ring position model
    desc_t      cur_desc;
    int         cur_slot;
    int         cur_word;                   // Buffer start, word index
    int         cur_len;
    int         byte_cnt;
    logic       in_frame;
    int         polls;
    int         mac_cnt;                    // Status delay after eop
    logic       stat_taken;
    tx_status_t acc_stat;
    logic       exp_txb;
    logic       exp_txe;
    logic       report_pending;
    logic       prev_stall;
    byte_t      prev_data;
    logic       prev_sop;
    logic       prev_eop;
    int         stall_cnt;
    int         frames_done;
    int         frame_err_base;
    int         checks;
    int         errors;

    eth_txdma eth_txdma_inst (.*);

    assign bd_desc = desc_ram[bd_index[2:0]];
    assign bd_ptr  = ptr_ram[bd_index[2:0]];

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    // **************************************************
    // Helpers
    // **************************************************
    function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
        int unsigned r;
        r = $random(seed);
        return lo + (r % (hi - lo + 1));
    endfunction

    function automatic data_t fill_word(input int unsigned a);
        return data_t'(a * 32'h9E37_79B1) ^ {a[15:0], ~a[15:0]};   // Every address bit matters
    endfunction

    function automatic byte_t frame_byte(input int k);
        data_t w;
        w = mem[cur_word + k / 4];
        return w[(k % 4) * 8 +: 8];         // LSB lane first
    endfunction

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_desc(input string name, input desc_t got, input desc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_index(input string name, input bd_index_t got, input bd_index_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    // Software fills a slot with a fresh frame, ready now or later
    task automatic arm_slot(input int slot, input int delay);
        desc_t d;
        d                        = '0;
        d[BIT_LEN_H:BIT_LEN_L]   = frame_len_t'(rand_range(1, MAX_LEN));
        d[BIT_READY]             = (delay == 0);
        d[BIT_IRQ]               = (rand_range(0, 3) != 0);
        d[BIT_WRAP]              = (rand_range(0, 3) == 0);
        d[BIT_PAD]               = (rand_range(0, 1) == 1);
        d[BIT_CRC]               = (rand_range(0, 1) == 1);
        d[BIT_STAT_H:BIT_STAT_L] = tx_status_t'(rand_range(0, 511));  // Stale status
        desc_ram[slot]           = d;
        ready_in[slot]           = delay;
        ptr_ram[slot]            = addr_t'(rand_range(0, MEM_WORDS - MAX_LEN / 4 - 1) * 4
                                           + rand_range(0, 3));
    endtask

    function automatic int ready_delay();
        return (rand_range(0, 3) == 0) ? int'(rand_range(20, 150)) : 0;
    endfunction

    // **************************************************
    // Posedge sampling and checks
    // **************************************************
    task automatic sample_outputs();
        desc_t exp_d;
        int    lat;
        int    due;
        cyc++;
        check_flag("txb_irq", txb_irq, exp_txb);   // Pulse one cycle after writeback
        check_flag("txe_irq", txe_irq, exp_txe);
        exp_txb = 1'b0;
        exp_txe = 1'b0;
        if (report_pending) begin
            $display("Frame %0d slot %0d len %0d polls %0d: %s", frames_done, cur_slot,
                     cur_len, polls, (errors == frame_err_base) ? "ok" : "errors");
            report_pending = 1'b0;
            polls          = 0;
            frames_done++;
        end
        if (bd_read && !bd_wait) begin
            check_index("bd_index", bd_index, exp_idx);
            if (bd_desc[BIT_READY]) begin
                if (in_frame) begin
                    report_fault("descriptor read while a frame is still streaming");
                end
                cur_desc       = bd_desc;
                cur_slot       = int'(bd_index);
                cur_len        = int'(bd_desc[BIT_LEN_H:BIT_LEN_L]);
                cur_word       = int'(bd_ptr >> 2);       // Low pointer bits ignored
                byte_cnt       = 0;
                in_frame       = 1'b1;
                frame_err_base = errors;
            end else begin
                polls++;                              // Same slot expected again
            end
        end
        if (av_read && !av_waitrequest) begin
            lat = int'(rand_range(1, 4));
            due = cyc + lat;
            if (due <= last_due) begin
                due = last_due + 1;               // One return per cycle, in order
            end
            last_due = due;
            due_q.push_back(due);
            if (av_address < addr_t'(MEM_WORDS * 4)) begin
                rdata_q.push_back(mem[int'(av_address >> 2)]);
            end else begin
                report_fault("read address outside the memory model");
                rdata_q.push_back('0);
            end
        end
        if (prev_stall) begin
            check_flag("tx_dv", tx_dv, 1'b1);    // Stalled byte must hold
            check_byte("tx_data", tx_data, prev_data);
            check_flag("tx_sop", tx_sop, prev_sop);
            check_flag("tx_eop", tx_eop, prev_eop);
        end
        prev_stall = tx_dv && !tx_ack;
        prev_data  = tx_data;
        prev_sop   = tx_sop;
        prev_eop   = tx_eop;
        if (tx_dv && tx_ack) begin
            if (!in_frame) begin
                report_fault("byte transferred with no frame in progress");
            end else begin
                check_byte("tx_data", tx_data, frame_byte(byte_cnt));
                check_flag("tx_sop", tx_sop, byte_cnt == 0);
                check_flag("tx_eop", tx_eop, byte_cnt == cur_len - 1);
                check_flag("per_packet_pad", per_packet_pad, cur_desc[BIT_PAD]);
                check_flag("per_packet_crc", per_packet_crc, cur_desc[BIT_CRC]);
                byte_cnt++;
                if (byte_cnt == cur_len) begin
                    in_frame = 1'b0;
                    mac_cnt  = 3;                 // MAC reports status later
                end
            end
        end
        // Ring already waits when the MAC offers status
        check_flag("tx_stat_ack", tx_stat_ack, tx_stat_valid);
        if (tx_stat_ack) begin
            acc_stat   = tx_stat;
            stat_taken = 1'b1;
        end
        if (bd_write && !bd_wait) begin
            exp_d                        = cur_desc;
            exp_d[BIT_READY]             = 1'b0;
            exp_d[BIT_STAT_H:BIT_STAT_L] = acc_stat;
            check_index("bd_index", bd_index, exp_idx);
            check_desc("bd_writedata", bd_writedata, exp_d);
            exp_txb = cur_desc[BIT_IRQ] && ((acc_stat & STAT_ERR_MASK) == '0);
            exp_txe = cur_desc[BIT_IRQ] && ((acc_stat & STAT_ERR_MASK) != '0);
            if (cur_desc[BIT_WRAP] || exp_idx == max_tx_bd) begin
                exp_idx = '0;
            end else begin
                exp_idx = exp_idx + 7'd1;
            end
            rearm_slot     = cur_slot;           // Refill at the next falling edge
            report_pending = 1'b1;
        end
    endtask

    // **************************************************
    // Negedge input drive
    // **************************************************
    task automatic drive_inputs();
        bd_wait        = (rand_range(0, 3) == 0);
        av_waitrequest = (rand_range(0, 2) == 0);
        if (stall_cnt > 0) begin
            tx_ack = 1'b0;
            stall_cnt--;
        end else if (rand_range(0, 63) == 0) begin
            tx_ack    = 1'b0;
            stall_cnt = int'(rand_range(20, 60));   // Long MAC stall
        end else begin
            tx_ack = (rand_range(0, 3) != 0);
        end
        if (due_q.size() > 0 && due_q[0] <= cyc + 1) begin
            av_readdatavalid = 1'b1;
            av_readdata      = rdata_q.pop_front();
            void'(due_q.pop_front());
        end else begin
            av_readdatavalid = 1'b0;
            av_readdata      = '0;
        end
        if (stat_taken) begin
            tx_stat_valid = 1'b0;
            stat_taken    = 1'b0;
        end
        if (mac_cnt > 0) begin
            mac_cnt--;
            if (mac_cnt == 0) begin
                tx_stat_valid = 1'b1;
                if (rand_range(0, 1) == 0) begin
                    tx_stat = tx_status_t'(rand_range(0, 15) << 4);   // Retry count only
                end else begin
                    tx_stat = tx_status_t'(rand_range(0, 511));
                end
            end
        end
        for (int i = 0; i < N_SLOTS; i++) begin
            if (ready_in[i] > 0) begin
                ready_in[i]--;
                if (ready_in[i] == 0) begin
                    desc_ram[i][BIT_READY] = 1'b1;   // Software hands slot over
                end
            end
        end
        if (rearm_slot >= 0) begin
            arm_slot(rearm_slot, ready_delay());
            rearm_slot = -1;
        end
    endtask

    // Bus, descriptor and MAC models in one process
    initial begin
        bd_wait          = 1'b0;
        max_tx_bd        = 7'd7;
        tx_stat          = '0;
        tx_stat_valid    = 1'b0;
        av_waitrequest   = 1'b0;
        av_readdata      = '0;
        av_readdatavalid = 1'b0;
        tx_ack           = 1'b0;
        exp_idx          = '0;
        exp_txb          = 1'b0;
        exp_txe          = 1'b0;
        cur_desc         = '0;
        acc_stat         = '0;
        in_frame         = 1'b0;
        stat_taken       = 1'b0;
        report_pending   = 1'b0;
        prev_stall       = 1'b0;
        rearm_slot       = -1;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = fill_word(a);
        end
        for (int i = 0; i < N_SLOTS; i++) begin
            arm_slot(i, ready_delay());
        end
        forever begin
            @(posedge clk);
            if (!reset) begin
                sample_outputs();
            end
            @(negedge clk);
            drive_inputs();
        end
    end

    initial begin
        reset = 1'b1;
        tx_en = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        tx_en = 1'b1;
        wait (frames_done == N_FRAMES);
        repeat (4) @(posedge clk);
        $display("Frames: %0d, checks: %0d, errors: %0d", frames_done, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog, generous budget per frame
    initial begin
        #(N_FRAMES * 600 * PERIOD);
        $display("Timeout: only %0d of %0d frames completed", frames_done, N_FRAMES);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- vlog.f
source/txdma_pkg.sv
source/bd_ring_ctrl.sv
source/buffer_reader.sv
source/word_fifo.sv
source/byte_serializer.sv
source/eth_txdma.sv
testbench/tb_eth_txdma.sv

//--- Makefile
TOP = tb_eth_txdma

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
